//--- common/dcache_pkg.sv
package dcache_pkg;

    ////////////////////
    // cache geometry.
    ////////////////////
    localparam int ways      = 4;
    localparam int sets      = 16;
    localparam int line_bits = 512;
    localparam int word_bits = 32;

    // address fields are tag 31:10, index 9:6, word 5:2, byte 1:0.
    localparam int tag_w   = 22;
    localparam int index_w = 4;

    // load and store size codes carry one bit per byte lane.
    localparam logic [3:0] size_byte = 4'b0001;
    localparam logic [3:0] size_half = 4'b0011;
    localparam logic [3:0] size_word = 4'b1111;

    typedef logic [ways-1:0] way_onehot;

    typedef enum logic [2:0] {
        idle,
        lookup,
        wb_req,
        refill_req,
        done
    } ctrl_state;

endpackage

//--- dcache/dcache_arrays.sv
`timescale 1ns/10ps
module dcache_arrays (
    input  logic clk,
    input  logic arst_n,
    input  logic [dcache_pkg::index_w-1:0] rd_index,
    input  logic wr_en,
    input  dcache_pkg::way_onehot wr_way,
    input  logic [dcache_pkg::index_w-1:0] wr_index,
    input  logic [dcache_pkg::tag_w-1:0] wr_tag,
    input  logic [dcache_pkg::line_bits-1:0] wr_line,
    input  logic wr_dirty,
    output logic [dcache_pkg::ways-1:0][dcache_pkg::tag_w-1:0] tag_out,
    output logic [dcache_pkg::ways-1:0] valid_out,
    output logic [dcache_pkg::ways-1:0] dirty_out,
    output logic [dcache_pkg::ways*dcache_pkg::line_bits-1:0] line_out
);

    logic [dcache_pkg::tag_w-1:0]     tag_mem  [dcache_pkg::ways][dcache_pkg::sets];
    logic [dcache_pkg::line_bits-1:0] data_mem [dcache_pkg::ways][dcache_pkg::sets];
    logic [dcache_pkg::ways-1:0]      valid_q  [dcache_pkg::sets];
    logic [dcache_pkg::ways-1:0]      dirty_q  [dcache_pkg::sets];

    ////////////////////
    // tag and data storage.
    ////////////////////
    always_ff @(posedge clk) begin
        for (int w = 0; w < dcache_pkg::ways; w++) begin
            if (wr_en && wr_way[w]) begin
                tag_mem[w][wr_index]  <= wr_tag;
                data_mem[w][wr_index] <= wr_line;
            end
            // read returns the old contents on a same-edge write.
            tag_out[w] <= tag_mem[w][rd_index];
            line_out[w*dcache_pkg::line_bits +: dcache_pkg::line_bits] <= data_mem[w][rd_index];
        end
    end

    ////////////////////
    // line state bits.
    ////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q   <= '{default: '0};
            dirty_q   <= '{default: '0};
            valid_out <= '0;
            dirty_out <= '0;
        end else begin
            if (wr_en) begin
                for (int w = 0; w < dcache_pkg::ways; w++) begin
                    if (wr_way[w]) begin
                        valid_q[wr_index][w] <= 1'b1;
                        dirty_q[wr_index][w] <= wr_dirty;
                    end
                end
            end
            valid_out <= valid_q[rd_index];
            dirty_out <= dirty_q[rd_index];
        end
    end

endmodule

//--- dcache/dcache_rd_sel.sv
`timescale 1ns/10ps
module dcache_rd_sel (
    input  logic [dcache_pkg::ways*dcache_pkg::line_bits-1:0] line_out,
    input  logic [dcache_pkg::line_bits-1:0] mem_dat_r,
    input  dcache_pkg::way_onehot hit_way,
    input  dcache_pkg::way_onehot victim_way,
    input  logic        from_refill,
    input  logic [31:0] req_adr,
    input  logic [3:0]  req_size,
    output logic [31:0] load_data,
    output logic [dcache_pkg::line_bits-1:0] sel_line,
    output logic [dcache_pkg::line_bits-1:0] victim_line
);

    logic [dcache_pkg::line_bits-1:0] way_line;
    logic [dcache_pkg::word_bits-1:0] sel_word;

    always_comb begin
        way_line = '0;
        for (int w = 0; w < dcache_pkg::ways; w++) begin
            if (hit_way[w]) way_line = line_out[w*dcache_pkg::line_bits +: dcache_pkg::line_bits];
        end
    end

    assign sel_line = from_refill ? mem_dat_r : way_line;
    assign sel_word = sel_line[req_adr[5:2]*dcache_pkg::word_bits +: dcache_pkg::word_bits];

    ////////////////////
    // load extraction.
    ////////////////////
    always_comb begin
        case (req_size)
            dcache_pkg::size_byte: begin
                case (req_adr[1:0])
                    2'd0: load_data = {{24{sel_word[7]}}, sel_word[7:0]};
                    2'd1: load_data = {{24{sel_word[15]}}, sel_word[15:8]};
                    2'd2: load_data = {{24{sel_word[23]}}, sel_word[23:16]};
                    default: load_data = {{24{sel_word[31]}}, sel_word[31:24]};
                endcase
            end
            dcache_pkg::size_half: begin
                case (req_adr[1:0])
                    2'd0: load_data = {{16{sel_word[15]}}, sel_word[15:0]};
                    2'd2: load_data = {{16{sel_word[31]}}, sel_word[31:16]};
                    default: load_data = '0;  // misaligned half.
                endcase
            end
            dcache_pkg::size_word: load_data = sel_word;
            default: load_data = '0;
        endcase
    end

    // victim line for write-back.
    always_comb begin
        victim_line = '0;
        for (int w = 0; w < dcache_pkg::ways; w++) begin
            if (victim_way[w]) begin
                victim_line = line_out[w*dcache_pkg::line_bits +: dcache_pkg::line_bits];
            end
        end
    end

endmodule

//--- dcache/dcache_store_merge.sv
`timescale 1ns/10ps
module dcache_store_merge (
    input  logic [dcache_pkg::line_bits-1:0] sel_line,
    input  logic [31:0] req_adr,
    input  logic [3:0]  req_size,
    input  logic [31:0] cpu_dat_w,
    output logic [dcache_pkg::line_bits-1:0] merged_line
);

    logic [dcache_pkg::word_bits-1:0] old_word;
    logic [dcache_pkg::word_bits-1:0] new_word;

    assign old_word = sel_line[req_adr[5:2]*dcache_pkg::word_bits +: dcache_pkg::word_bits];

    // lane merge inside the addressed word.
    always_comb begin
        new_word = old_word;
        case (req_size)
            dcache_pkg::size_byte: new_word[req_adr[1:0]*8 +: 8] = cpu_dat_w[7:0];
            dcache_pkg::size_half: begin
                if (!req_adr[0]) new_word[req_adr[1]*16 +: 16] = cpu_dat_w[15:0];
            end
            dcache_pkg::size_word: new_word = cpu_dat_w;
            default: new_word = old_word;
        endcase
    end

    always_comb begin
        merged_line = sel_line;
        merged_line[req_adr[5:2]*dcache_pkg::word_bits +: dcache_pkg::word_bits] = new_word;
    end

endmodule

//--- dcache/dcache_ctrl.sv
`timescale 1ns/10ps
module dcache_ctrl (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        cpu_cyc,
    input  logic        cpu_stb,
    input  logic        cpu_we,
    input  logic [31:0] cpu_adr,
    input  logic [3:0]  cpu_size,
    output logic        cpu_ack,
    output logic [31:0] cpu_dat_r,
    output logic        mem_cyc,
    output logic        mem_stb,
    output logic        mem_we,
    output logic [31:0] mem_adr,
    input  logic [dcache_pkg::line_bits-1:0] mem_dat_r,
    input  logic        mem_ack,
    output logic [dcache_pkg::index_w-1:0] rd_index,
    output logic        wr_en,
    output dcache_pkg::way_onehot wr_way,
    output logic [dcache_pkg::index_w-1:0] wr_index,
    output logic [dcache_pkg::tag_w-1:0] wr_tag,
    output logic [dcache_pkg::line_bits-1:0] wr_line,
    output logic        wr_dirty,
    input  logic [dcache_pkg::ways-1:0][dcache_pkg::tag_w-1:0] tag_out,
    input  logic [dcache_pkg::ways-1:0] valid_out,
    input  logic [dcache_pkg::ways-1:0] dirty_out,
    input  logic [31:0] load_data,
    input  logic [dcache_pkg::line_bits-1:0] merged_line,
    output dcache_pkg::way_onehot hit_way,
    output dcache_pkg::way_onehot victim_way,
    output logic        from_refill,
    output logic [31:0] req_adr,
    output logic [3:0]  req_size
);

    dcache_pkg::ctrl_state          state;
    logic                           req_we;
    logic [dcache_pkg::index_w-1:0] req_index;
    logic                           hit;
    dcache_pkg::way_onehot          victim_c;
    logic [dcache_pkg::tag_w-1:0]   victim_tag;
    logic                           victim_dirty;
    logic [$clog2(dcache_pkg::ways)-1:0] rr_q [dcache_pkg::sets];

    assign req_index   = req_adr[9:6];
    // the arrays see the incoming index while idle, so tags are ready in lookup.
    assign rd_index    = (state == dcache_pkg::idle) ? cpu_adr[9:6] : req_index;
    assign wr_index    = req_index;
    assign wr_tag      = req_adr[31:10];
    assign from_refill = (state == dcache_pkg::refill_req);
    assign hit         = |hit_way;

    always_ff @(posedge clk) begin
        if (state == dcache_pkg::idle && cpu_cyc && cpu_stb) begin
            req_adr  <= cpu_adr;
            req_size <= cpu_size;
            req_we   <= cpu_we;
        end
    end

    ////////////////////
    // hit and victim.
    ////////////////////
    always_comb begin
        for (int w = 0; w < dcache_pkg::ways; w++) begin
            hit_way[w] = valid_out[w] && (tag_out[w] == req_adr[31:10]);
        end
    end

    always_comb begin
        victim_c = '0;
        if (&valid_out) begin
            victim_c = dcache_pkg::way_onehot'(1) << rr_q[req_index];
        end else begin
            // walk downwards so the lowest invalid way wins.
            for (int w = dcache_pkg::ways - 1; w >= 0; w--) begin
                if (!valid_out[w]) victim_c = dcache_pkg::way_onehot'(1) << w;
            end
        end
    end

    always_comb begin
        victim_tag   = '0;
        victim_dirty = 1'b0;
        for (int w = 0; w < dcache_pkg::ways; w++) begin
            if (victim_c[w]) begin
                victim_tag   = tag_out[w];
                victim_dirty = valid_out[w] && dirty_out[w];
            end
        end
    end

    ////////////////////
    // array writes.
    ////////////////////
    always_comb begin
        wr_en    = 1'b0;
        wr_way   = hit_way;
        wr_dirty = 1'b1;
        wr_line  = merged_line;
        if (state == dcache_pkg::lookup && hit && req_we) begin
            wr_en = 1'b1;
        end else if (state == dcache_pkg::refill_req && mem_cyc && mem_ack) begin
            wr_en    = 1'b1;
            wr_way   = victim_way;
            wr_dirty = req_we;
            wr_line  = req_we ? merged_line : mem_dat_r;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= dcache_pkg::idle;
            cpu_ack    <= 1'b0;
            cpu_dat_r  <= '0;
            mem_cyc    <= 1'b0;
            mem_stb    <= 1'b0;
            mem_we     <= 1'b0;
            mem_adr    <= '0;
            victim_way <= '0;
            rr_q       <= '{default: '0};
        end else begin
            cpu_ack <= 1'b0;
            case (state)
                dcache_pkg::idle: begin
                    if (cpu_cyc && cpu_stb) state <= dcache_pkg::lookup;
                end
                dcache_pkg::lookup: begin
                    victim_way <= victim_c;
                    if (hit) begin
                        cpu_ack   <= 1'b1;
                        cpu_dat_r <= load_data;
                        state     <= dcache_pkg::done;
                    end else begin
                        mem_cyc <= 1'b1;
                        mem_stb <= 1'b1;
                        mem_we  <= victim_dirty;
                        if (victim_dirty) begin
                            mem_adr <= {victim_tag, req_index, 6'b0};
                            state   <= dcache_pkg::wb_req;
                        end else begin
                            mem_adr <= {req_adr[31:6], 6'b0};
                            state   <= dcache_pkg::refill_req;
                        end
                    end
                end
                dcache_pkg::wb_req: begin
                    if (mem_ack) begin
                        mem_cyc <= 1'b0;
                        mem_stb <= 1'b0;
                        mem_we  <= 1'b0;
                        state   <= dcache_pkg::refill_req;
                    end
                end
                dcache_pkg::refill_req: begin
                    // after a write-back the bus is idle for one cycle first.
                    if (!mem_cyc) begin
                        mem_cyc <= 1'b1;
                        mem_stb <= 1'b1;
                        mem_adr <= {req_adr[31:6], 6'b0};
                    end else if (mem_ack) begin
                        mem_cyc          <= 1'b0;
                        mem_stb          <= 1'b0;
                        cpu_ack          <= 1'b1;
                        cpu_dat_r        <= load_data;
                        rr_q[req_index]  <= rr_q[req_index] + 1'b1;
                        state            <= dcache_pkg::done;
                    end
                end
                default: state <= dcache_pkg::idle;
            endcase
        end
    end

endmodule

//--- hw/dcache_top.sv
`timescale 1ns/10ps
module dcache_top (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        cpu_cyc,
    input  logic        cpu_stb,
    input  logic        cpu_we,
    input  logic [31:0] cpu_adr,
    input  logic [3:0]  cpu_size,
    input  logic [31:0] cpu_dat_w,
    output logic [31:0] cpu_dat_r,
    output logic        cpu_ack,
    output logic        mem_cyc,
    output logic        mem_stb,
    output logic        mem_we,
    output logic [31:0] mem_adr,
    output logic [dcache_pkg::line_bits-1:0] mem_dat_w,
    input  logic [dcache_pkg::line_bits-1:0] mem_dat_r,
    input  logic        mem_ack
);

    logic [dcache_pkg::index_w-1:0]                    rd_index;
    logic                                              wr_en;
    dcache_pkg::way_onehot                             wr_way;
    logic [dcache_pkg::index_w-1:0]                    wr_index;
    logic [dcache_pkg::tag_w-1:0]                      wr_tag;
    logic [dcache_pkg::line_bits-1:0]                  wr_line;
    logic                                              wr_dirty;
    logic [dcache_pkg::ways-1:0][dcache_pkg::tag_w-1:0] tag_out;
    logic [dcache_pkg::ways-1:0]                       valid_out;
    logic [dcache_pkg::ways-1:0]                       dirty_out;
    logic [dcache_pkg::ways*dcache_pkg::line_bits-1:0] line_out;
    dcache_pkg::way_onehot                             hit_way;
    dcache_pkg::way_onehot                             victim_way;
    logic                                              from_refill;
    logic [31:0]                                       req_adr;
    logic [3:0]                                        req_size;
    logic [31:0]                                       load_data;
    logic [dcache_pkg::line_bits-1:0]                  sel_line;
    logic [dcache_pkg::line_bits-1:0]                  merged_line;

    dcache_ctrl u_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .cpu_cyc     (cpu_cyc),
        .cpu_stb     (cpu_stb),
        .cpu_we      (cpu_we),
        .cpu_adr     (cpu_adr),
        .cpu_size    (cpu_size),
        .cpu_ack     (cpu_ack),
        .cpu_dat_r   (cpu_dat_r),
        .mem_cyc     (mem_cyc),
        .mem_stb     (mem_stb),
        .mem_we      (mem_we),
        .mem_adr     (mem_adr),
        .mem_dat_r   (mem_dat_r),
        .mem_ack     (mem_ack),
        .rd_index    (rd_index),
        .wr_en       (wr_en),
        .wr_way      (wr_way),
        .wr_index    (wr_index),
        .wr_tag      (wr_tag),
        .wr_line     (wr_line),
        .wr_dirty    (wr_dirty),
        .tag_out     (tag_out),
        .valid_out   (valid_out),
        .dirty_out   (dirty_out),
        .load_data   (load_data),
        .merged_line (merged_line),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .from_refill (from_refill),
        .req_adr     (req_adr),
        .req_size    (req_size)
    );

    dcache_arrays u_arrays (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_index  (rd_index),
        .wr_en     (wr_en),
        .wr_way    (wr_way),
        .wr_index  (wr_index),
        .wr_tag    (wr_tag),
        .wr_line   (wr_line),
        .wr_dirty  (wr_dirty),
        .tag_out   (tag_out),
        .valid_out (valid_out),
        .dirty_out (dirty_out),
        .line_out  (line_out)
    );

    dcache_rd_sel u_rd_sel (
        .line_out    (line_out),
        .mem_dat_r   (mem_dat_r),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .from_refill (from_refill),
        .req_adr     (req_adr),
        .req_size    (req_size),
        .load_data   (load_data),
        .sel_line    (sel_line),
        .victim_line (mem_dat_w)
    );

    dcache_store_merge u_store_merge (
        .sel_line    (sel_line),
        .req_adr     (req_adr),
        .req_size    (req_size),
        .cpu_dat_w   (cpu_dat_w),
        .merged_line (merged_line)
    );

endmodule

//--- verif/dcache_properties.sv
`timescale 1ns/10ps
module dcache_properties (
    input logic                             clk,
    input logic                             arst_n,
    input logic                             cpu_cyc,
    input logic                             cpu_stb,
    input logic                             cpu_ack,
    input logic                             mem_cyc,
    input logic                             mem_stb,
    input logic                             mem_we,
    input logic                             mem_ack,
    input logic [31:0]                      mem_adr,
    input logic [dcache_pkg::line_bits-1:0] mem_dat_w,
    input dcache_pkg::ctrl_state            state
);

    int prop_fails = 0;

    ack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        cpu_ack |-> cpu_cyc && cpu_stb && state == dcache_pkg::done)
        else begin
            $error("cpu_ack outside an active cpu bus cycle");
            prop_fails++;
        end

    ack_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        cpu_ack |=> !cpu_ack)
        else begin
            $error("cpu_ack held for more than one cycle");
            prop_fails++;
        end

    stb_in_cyc: assert property (@(posedge clk) disable iff (!arst_n)
        mem_stb |-> mem_cyc)
        else begin
            $error("mem_stb without mem_cyc");
            prop_fails++;
        end

    // the memory request holds until the slave answers.
    mem_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (mem_stb && !mem_ack) |=> mem_stb && $stable(mem_adr) && $stable(mem_we))
        else begin
            $error("memory request changed before mem_ack");
            prop_fails++;
        end

    mem_wdat_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (mem_stb && mem_we && !mem_ack) |=> $stable(mem_dat_w))
        else begin
            $error("write-back data changed before mem_ack");
            prop_fails++;
        end

    quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> !cpu_ack && !mem_cyc && !mem_stb && !mem_we)
        else begin
            $error("control output active during reset");
            prop_fails++;
        end

endmodule

bind dcache_top dcache_properties u_props (
    .clk       (clk),
    .arst_n    (arst_n),
    .cpu_cyc   (cpu_cyc),
    .cpu_stb   (cpu_stb),
    .cpu_ack   (cpu_ack),
    .mem_cyc   (mem_cyc),
    .mem_stb   (mem_stb),
    .mem_we    (mem_we),
    .mem_ack   (mem_ack),
    .mem_adr   (mem_adr),
    .mem_dat_w (mem_dat_w),
    .state     (u_ctrl.state)
);

//--- verif/dcache_tb.sv
`timescale 1ns/10ps
module dcache_tb;

    localparam int hit_cycles = 2;
    localparam int ack_limit  = 200;

    logic        clk;
    logic        arst_n;
    logic        cpu_cyc;
    logic        cpu_stb;
    logic        cpu_we;
    logic [31:0] cpu_adr;
    logic [3:0]  cpu_size;
    logic [31:0] cpu_dat_w;
    logic [31:0] cpu_dat_r;
    logic        cpu_ack;
    logic        mem_cyc;
    logic        mem_stb;
    logic        mem_we;
    logic [31:0] mem_adr;
    logic [dcache_pkg::line_bits-1:0] mem_dat_w;
    logic [dcache_pkg::line_bits-1:0] mem_dat_r;
    logic        mem_ack;

    logic [511:0] mem_lines [logic [25:0]];
    logic [7:0]   shadow [logic [31:0]];
    int           wb_count = 0;
    int           checks = 0;
    int           errors = 0;
    int           tests = 0;
    int           test_start_errors = 0;
    logic         hung = 1'b0;

    dcache_top UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_cyc   (cpu_cyc),
        .cpu_stb   (cpu_stb),
        .cpu_we    (cpu_we),
        .cpu_adr   (cpu_adr),
        .cpu_size  (cpu_size),
        .cpu_dat_w (cpu_dat_w),
        .cpu_dat_r (cpu_dat_r),
        .cpu_ack   (cpu_ack),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_we    (mem_we),
        .mem_adr   (mem_adr),
        .mem_dat_w (mem_dat_w),
        .mem_dat_r (mem_dat_r),
        .mem_ack   (mem_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////
    // memory and shadow.
    ////////////////////
    function automatic void touch_line(input logic [31:0] a);
        logic [511:0] line;
        if (!mem_lines.exists(a[31:6])) begin
            for (int w = 0; w < 16; w++) line[w*32 +: 32] = $urandom;
            mem_lines[a[31:6]] = line;
            for (int b = 0; b < 64; b++) shadow[{a[31:6], 6'b0} + b] = line[b*8 +: 8];
        end
    endfunction

    function automatic void shadow_store(input logic [31:0] a, input logic [3:0] size,
                                         input logic [31:0] d);
        case (size)
            dcache_pkg::size_byte: shadow[a] = d[7:0];
            dcache_pkg::size_half: begin
                if (!a[0]) begin
                    shadow[a]     = d[7:0];
                    shadow[a + 1] = d[15:8];
                end
            end
            dcache_pkg::size_word: begin
                for (int b = 0; b < 4; b++) shadow[{a[31:2], 2'b00} + b] = d[b*8 +: 8];
            end
            default: ;
        endcase
    endfunction

    function automatic logic [31:0] expect_load(input logic [31:0] a, input logic [3:0] size);
        logic [31:0] base;
        logic [7:0]  lo;
        logic [7:0]  hi;
        base = {a[31:2], 2'b00};
        case (size)
            dcache_pkg::size_byte: begin
                lo = shadow[a];
                return {{24{lo[7]}}, lo};
            end
            dcache_pkg::size_half: begin
                if (a[0]) return 32'h0;
                lo = shadow[a];
                hi = shadow[a + 1];
                return {{16{hi[7]}}, hi, lo};
            end
            dcache_pkg::size_word: begin
                return {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
            end
            default: return 32'h0;
        endcase
    endfunction

    // line memory slave with 0 to 3 wait states.
    task automatic serve_memory();
        logic [25:0]  key;
        logic         we;
        logic [511:0] wdat;
        forever begin
            @(negedge clk);
            if (mem_cyc && mem_stb && !mem_ack) begin
                key  = mem_adr[31:6];
                we   = mem_we;
                wdat = mem_dat_w;
                repeat ($urandom_range(3, 0)) @(negedge clk);
                @(posedge clk);
                if (we) begin
                    mem_lines[key] = wdat;
                    wb_count++;
                end else begin
                    mem_dat_r <= mem_lines[key];
                end
                mem_ack <= 1'b1;
                @(posedge clk);
                mem_ack <= 1'b0;
            end
        end
    endtask

    ////////////////////
    // cpu side.
    ////////////////////
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic cpu_access(input logic we, input logic [31:0] adr, input logic [3:0] size,
                              input logic [31:0] wdat, output logic [31:0] rdat,
                              output int lat);
        int n;
        rdat = '0;
        lat  = 0;
        if (hung) return;
        touch_line(adr);
        @(posedge clk);
        cpu_cyc   <= 1'b1;
        cpu_stb   <= 1'b1;
        cpu_we    <= we;
        cpu_adr   <= adr;
        cpu_size  <= size;
        cpu_dat_w <= wdat;
        n = 0;
        @(negedge clk);
        while (!cpu_ack && n < ack_limit) begin
            @(negedge clk);
            n++;
        end
        if (!cpu_ack) begin
            $display("timeout: no cpu_ack within %0d cycles for address %h", ack_limit, adr);
            errors++;
            hung = 1'b1;
        end
        rdat = cpu_dat_r;
        lat  = n;
        @(posedge clk);
        cpu_cyc <= 1'b0;
        cpu_stb <= 1'b0;
        if (we) shadow_store(adr, size, wdat);
    endtask

    task automatic store(input logic [31:0] adr, input logic [3:0] size, input logic [31:0] d);
        logic [31:0] unused;
        int          lat;
        cpu_access(1'b1, adr, size, d, unused, lat);
    endtask

    task automatic load_check(input logic [31:0] adr, input logic [3:0] size);
        logic [31:0] got;
        int          lat;
        cpu_access(1'b0, adr, size, 32'h0, got, lat);
        check_value($sformatf("load %h size %b", adr, size), got, expect_load(adr, size));
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s finished with %0d errors", tests, name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    initial begin
        logic [31:0] got;
        int          lat;
        logic [31:0] adr;
        logic [3:0]  size;
        logic [25:0] evict_key;
        int          wb_before;
        int          total;
        void'($urandom(32'hf714_7946));
        arst_n    = 1'b0;
        cpu_cyc   = 1'b0;
        cpu_stb   = 1'b0;
        cpu_we    = 1'b0;
        cpu_adr   = '0;
        cpu_size  = '0;
        cpu_dat_w = '0;
        mem_dat_r = '0;
        mem_ack   = 1'b0;
        fork
            serve_memory();
        join_none
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;

        cpu_access(1'b0, 32'h0000_1040, dcache_pkg::size_word, 32'h0, got, lat);
        check_value("miss load", got, expect_load(32'h0000_1040, dcache_pkg::size_word));
        check_value("miss slower than hit", 32'(lat > hit_cycles), 32'd1);
        cpu_access(1'b0, 32'h0000_1040, dcache_pkg::size_word, 32'h0, got, lat);
        check_value("hit load", got, expect_load(32'h0000_1040, dcache_pkg::size_word));
        check_value("hit latency", lat, hit_cycles);
        finish_test("miss_then_hit");

        // negative and positive bytes and halves.
        store(32'h0000_2080, dcache_pkg::size_word, 32'h807f_ff01);
        store(32'h0000_2084, dcache_pkg::size_word, 32'h7fff_0080);
        for (int w = 0; w < 2; w++) begin
            for (int b = 0; b < 4; b++) load_check(32'h0000_2080 + w*4 + b, dcache_pkg::size_byte);
            load_check(32'h0000_2080 + w*4, dcache_pkg::size_half);
            load_check(32'h0000_2082 + w*4, dcache_pkg::size_half);
        end
        finish_test("load_sign_extension");

        store(32'h0000_1041, dcache_pkg::size_byte, 32'h0000_00c3);
        store(32'h0000_1046, dcache_pkg::size_half, 32'h0000_9a5e);
        store(32'h0000_1048, dcache_pkg::size_word, 32'h1357_9bdf);
        store(32'h0000_30c3, dcache_pkg::size_byte, 32'h0000_0077);
        store(32'h0000_3106, dcache_pkg::size_half, 32'h0000_8421);
        store(32'h0000_3148, dcache_pkg::size_word, 32'hcafe_f00d);
        load_check(32'h0000_1040, dcache_pkg::size_word);
        load_check(32'h0000_1044, dcache_pkg::size_word);
        load_check(32'h0000_1048, dcache_pkg::size_word);
        load_check(32'h0000_30c0, dcache_pkg::size_word);
        load_check(32'h0000_3104, dcache_pkg::size_word);
        load_check(32'h0000_3148, dcache_pkg::size_word);
        finish_test("stores");

        // set 7 fills with four dirty lines and the fifth evicts way 0.
        for (int i = 0; i < 4; i++) begin
            store(32'h0001_01cc + (i << 10), dcache_pkg::size_word, 32'ha5a5_0000 + i);
        end
        wb_before = wb_count;
        evict_key = 26'(32'h0001_01c0 >> 6);
        load_check(32'h0001_11c0, dcache_pkg::size_word);
        check_value("write-back count", wb_count - wb_before, 32'd1);
        for (int w = 0; w < 16; w++) begin
            check_value($sformatf("evicted word %0d", w), mem_lines[evict_key][w*32 +: 32],
                        expect_load(32'h0001_01c0 + w*4, dcache_pkg::size_word));
        end
        finish_test("dirty_eviction");

        // small tag pool over sets 8 to 15 mixes hits, misses and write-backs.
        for (int i = 0; i < 40; i++) begin
            adr = {22'(32'h100 + $urandom_range(7, 0)), 1'b1, 3'($urandom_range(7, 0)),
                   6'($urandom_range(63, 0))};
            case ($urandom_range(2, 0))
                0: size = dcache_pkg::size_byte;
                1: size = dcache_pkg::size_half;
                default: begin
                    size = dcache_pkg::size_word;
                    adr[1:0] = 2'b00;
                end
            endcase
            if ($urandom_range(1, 0) == 1) store(adr, size, $urandom);
            else load_check(adr, size);
        end
        finish_test("wait_states");

        cpu_access(1'b0, 32'h0000_4281, dcache_pkg::size_half, 32'h0, got, lat);
        check_value("misaligned half load", got, 32'h0);
        load_check(32'h0000_4280, 4'b0111);
        store(32'h0000_4283, dcache_pkg::size_half, 32'h0000_beef);
        load_check(32'h0000_4280, dcache_pkg::size_word);
        finish_test("misaligned_half");

        total = errors + UUT.u_props.prop_fails;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, total);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- dcache.f
common/dcache_pkg.sv
dcache/dcache_arrays.sv
dcache/dcache_rd_sel.sv
dcache/dcache_store_merge.sv
dcache/dcache_ctrl.sv
hw/dcache_top.sv
verif/dcache_properties.sv
verif/dcache_tb.sv
